/* vlog.f */
mem_pkg.sv
addr_decode.sv
cache_level.sv
resp_merge.sv
internal_system_top.sv
tb_mem_model.sv
tb_internal_system.sv

/* tb_internal_system.sv */
// ----------------------------------------------------------------------
// testbench top, drives the core port and checks every answer against
// a reference model of the memory image, both caches and the counters
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_internal_system;

	localparam int TIMEOUT = 40;

	logic        clock_i, rst_i, cyc_i, stb_i, we_i, ack_o, err_o;
	logic [31:0] adr_i, dat_i, dat_o;
	logic        ext_cyc, ext_stb, ext_we, ext_ack, ext_err;
	logic [31:0] ext_adr, ext_wdat, ext_rdat;
	logic        per_cyc, per_stb, per_we, per_ack;
	logic [31:0] per_adr, per_wdat, per_rdat;
	logic [mem_pkg::CNT_W-1:0] l1_hits, l2_hits, ext_reads;

	// reference model
	logic [31:0] exp_mem [int];
	int          l1_tag [mem_pkg::L1_LINES];
	int          l2_tag [mem_pkg::L2_LINES];
	int          exp_l1, exp_l2, exp_ext;
	logic [31:0] rdat, a;
	logic        got_err;
	int          lat;

	internal_system_top u_dut (
		.clock_i (clock_i), .rst_i (rst_i),
		.cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i), .dat_i (dat_i),
		.dat_o (dat_o), .ack_o (ack_o), .err_o (err_o),
		.ext_cyc_o (ext_cyc), .ext_stb_o (ext_stb), .ext_we_o (ext_we),
		.ext_adr_o (ext_adr), .ext_dat_o (ext_wdat), .ext_dat_i (ext_rdat),
		.ext_ack_i (ext_ack), .ext_err_i (ext_err),
		.per_cyc_o (per_cyc), .per_stb_o (per_stb), .per_we_o (per_we),
		.per_adr_o (per_adr), .per_dat_o (per_wdat), .per_dat_i (per_rdat),
		.per_ack_i (per_ack),
		.l1_hits_o (l1_hits), .l2_hits_o (l2_hits), .ext_reads_o (ext_reads)
	);

	tb_mem_model u_mem (
		.clock_i (clock_i), .rst_i (rst_i),
		.ext_cyc_i (ext_cyc), .ext_stb_i (ext_stb), .ext_we_i (ext_we),
		.ext_adr_i (ext_adr), .ext_dat_i (ext_wdat), .ext_dat_o (ext_rdat),
		.ext_ack_o (ext_ack), .ext_err_o (ext_err),
		.per_cyc_i (per_cyc), .per_stb_i (per_stb), .per_we_i (per_we),
		.per_adr_i (per_adr), .per_dat_i (per_wdat), .per_dat_o (per_rdat),
		.per_ack_o (per_ack)
	);

	initial begin
		clock_i = 1'b0;
		forever #5 clock_i = ~clock_i;
	end

	task automatic halt(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	// one classic cycle with latency counted from the first sampled strobe
	task automatic access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rd, output logic err, output int n);
		n = 1;
		@(posedge clock_i);
		#1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = adr;
		dat_i = wdat;
		@(posedge clock_i);
		@(negedge clock_i);
		while (!ack_o && !err_o) begin
			if (n == TIMEOUT) begin
				halt($sformatf("timeout: no ack or err for address %h", adr));
			end
			n++;
			@(negedge clock_i);
		end
		rd  = dat_o;
		err = err_o;
		@(posedge clock_i);
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic check_counters();
		assert (l1_hits == exp_l1 && l2_hits == exp_l2 && ext_reads == exp_ext)
		else halt($sformatf("FAIL @ %0t ns: counters %0d %0d %0d, expected %0d %0d %0d",
			$time, l1_hits, l2_hits, ext_reads, exp_l1, exp_l2, exp_ext));
	endtask

	task automatic mem_write(input logic [31:0] adr, input logic [31:0] wdat);
		access(1'b1, adr, wdat, rdat, got_err, lat);
		assert (!got_err) else halt($sformatf("FAIL @ %0t ns: err on write %h", $time, adr));
		exp_mem[adr[15:2]] = wdat;
		check_counters();
	endtask

	task automatic mem_read(input logic [31:0] adr);
		int          w;
		int          exp_lat;
		logic        exp_err;
		logic [31:0] exp_dat;
		w       = adr[15:2];
		exp_err = (adr[15:8] == 8'hf0);
		exp_dat = exp_mem.exists(w) ? exp_mem[w] : 32'h5a00_0000 ^ (w * 32'h9e37_79b1);
		exp_lat = 0;
		if (l1_tag[w % mem_pkg::L1_LINES] == w) begin
			exp_lat = 1;
			exp_l1++;
		end else if (l2_tag[w % mem_pkg::L2_LINES] == w) begin
			// L1 hit latency plus two
			exp_lat = 3;
			exp_l2++;
			l1_tag[w % mem_pkg::L1_LINES] = w;
		end else if (!exp_err) begin
			exp_ext++;
			l1_tag[w % mem_pkg::L1_LINES] = w;
			l2_tag[w % mem_pkg::L2_LINES] = w;
		end
		access(1'b0, adr, '0, rdat, got_err, lat);
		assert (got_err == exp_err && (exp_err || rdat == exp_dat))
		else halt($sformatf("FAIL @ %0t ns: read %h gave %h err %b, expected %h err %b",
			$time, adr, rdat, got_err, exp_dat, exp_err));
		assert (exp_lat == 0 || lat == exp_lat)
		else halt($sformatf("FAIL @ %0t ns: read %h took %0d cycles, expected %0d",
			$time, adr, lat, exp_lat));
		check_counters();
	endtask

	// ack and err are exclusive and only ever answer a strobe
	always @(negedge clock_i) begin
		if (!rst_i) begin
			assert (!(ack_o && err_o)) else halt($sformatf("FAIL @ %0t ns: ack and err", $time));
			assert (stb_i || !(ack_o || err_o))
			else halt($sformatf("FAIL @ %0t ns: answer without request", $time));
		end
	end

	initial begin
		void'($urandom(32'h1f3fd439));
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		adr_i = '0;
		dat_i = '0;
		exp_l1  = 0;
		exp_l2  = 0;
		exp_ext = 0;
		foreach (l1_tag[i]) l1_tag[i] = -1;
		foreach (l2_tag[i]) l2_tag[i] = -1;
		repeat (3) @(posedge clock_i);
		#1;
		rst_i = 1'b0;

		// ------------------------------------------------------------------
		// reset state
		assert (!ack_o && !err_o && !ext_cyc && !ext_stb && !per_cyc && !per_stb)
		else halt($sformatf("FAIL @ %0t ns: strobes active after reset", $time));
		check_counters();

		// read after write over a small window with plenty of hits and aliasing
		repeat (60) begin
			a = $urandom_range(63, 0) << 2;
			if ($urandom_range(1, 0)) begin
				mem_write(a, $urandom);
			end else begin
				mem_read(a);
			end
		end

		// one external read, then L1 hits
		repeat (4) mem_read(32'h0000_0100);

		// aliases in L1 only so the second round comes from L2
		mem_read(32'h0000_0200);
		mem_read(32'h0000_0210);
		mem_read(32'h0000_0200);
		mem_read(32'h0000_0210);

		// ------------------------------------------------------------------
		// peripheral path leaves the counters alone
		access(1'b1, 32'h8000_0010, 32'hcafe_0001, rdat, got_err, lat);
		access(1'b0, 32'h8000_0010, '0, rdat, got_err, lat);
		assert (!got_err && rdat == 32'hcafe_0001)
		else halt($sformatf("FAIL @ %0t ns: peripheral read %h", $time, rdat));
		check_counters();

		// unmapped address and error window
		access(1'b0, 32'h4000_0000, '0, rdat, got_err, lat);
		assert (got_err && lat == 1)
		else halt($sformatf("FAIL @ %0t ns: unmapped err %b after %0d", $time, got_err, lat));
		mem_read(32'h0000_f004);
		mem_read(32'h0000_f004);

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* tb_mem_model.sv */
// ----------------------------------------------------------------------
// testbench external Wishbone memory with random wait and error window,
// plus a peripheral register bank that acks after one cycle
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_mem_model (
	input  logic        clock_i,
	input  logic        rst_i,
	input  logic        ext_cyc_i,
	input  logic        ext_stb_i,
	input  logic        ext_we_i,
	input  logic [31:0] ext_adr_i,
	input  logic [31:0] ext_dat_i,
	output logic [31:0] ext_dat_o,
	output logic        ext_ack_o,
	output logic        ext_err_o,
	input  logic        per_cyc_i,
	input  logic        per_stb_i,
	input  logic        per_we_i,
	input  logic [31:0] per_adr_i,
	input  logic [31:0] per_dat_i,
	output logic [31:0] per_dat_o,
	output logic        per_ack_o
);

	logic [31:0] mem [16384];
	logic [31:0] regs [64];
	logic        busy;
	int          wait_left;
	logic        ack_nx;
	logic        err_nx;
	logic        pack_nx;
	logic [31:0] rd_nx;
	logic [31:0] prd_nx;

	initial begin
		// fill word mixes in the whole word address
		for (int w = 0; w < 16384; w++) begin
			mem[w] = 32'h5a00_0000 ^ (w * 32'h9e37_79b1);
		end
		for (int r = 0; r < 64; r++) begin
			regs[r] = '0;
		end
		ext_dat_o = '0;
		ext_ack_o = 1'b0;
		ext_err_o = 1'b0;
		per_dat_o = '0;
		per_ack_o = 1'b0;
		busy      = 1'b0;
		wait_left = 0;
	end

	// decide on values seen at the edge, drive 1 ns later
	always begin
		@(posedge clock_i);
		ack_nx = 1'b0;
		err_nx = 1'b0;
		rd_nx  = ext_dat_o;
		prd_nx = per_dat_o;
		if (rst_i || !(ext_cyc_i && ext_stb_i)) begin
			busy = 1'b0;
		end else if (!ext_ack_o && !ext_err_o) begin
			if (!busy) begin
				busy      = 1'b1;
				wait_left = $urandom_range(3, 0);
			end
			if (wait_left > 0) begin
				wait_left--;
			end else begin
				busy = 1'b0;
				// error window 0xf000 to 0xf0ff
				if (ext_adr_i[15:8] == 8'hf0) begin
					err_nx = 1'b1;
				end else begin
					ack_nx = 1'b1;
					if (ext_we_i) begin
						mem[ext_adr_i[15:2]] = ext_dat_i;
					end
					rd_nx = mem[ext_adr_i[15:2]];
				end
			end
		end
		// peripheral side
		pack_nx = per_cyc_i && per_stb_i && !per_ack_o && !rst_i;
		if (pack_nx) begin
			if (per_we_i) begin
				regs[per_adr_i[7:2]] = per_dat_i;
			end
			prd_nx = regs[per_adr_i[7:2]];
		end
		#1;
		ext_ack_o = ack_nx;
		ext_err_o = err_nx;
		ext_dat_o = rd_nx;
		per_ack_o = pack_nx;
		per_dat_o = prd_nx;
	end

endmodule

/* internal_system_top.sv */
// ----------------------------------------------------------------------
// two-level cache memory subsystem between a core Wishbone port, an
// external Wishbone memory and a reduced peripheral bus
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module internal_system_top (
	input  logic                        clock_i,
	input  logic                        rst_i,
	// core port
	input  logic                        cyc_i,
	input  logic                        stb_i,
	input  logic                        we_i,
	input  logic [mem_pkg::ADDR_W-1:0]  adr_i,
	input  logic [mem_pkg::DATA_W-1:0]  dat_i,
	output logic [mem_pkg::DATA_W-1:0]  dat_o,
	output logic                        ack_o,
	output logic                        err_o,
	// external memory
	output logic                        ext_cyc_o,
	output logic                        ext_stb_o,
	output logic                        ext_we_o,
	output logic [mem_pkg::ADDR_W-1:0]  ext_adr_o,
	output logic [mem_pkg::DATA_W-1:0]  ext_dat_o,
	input  logic [mem_pkg::DATA_W-1:0]  ext_dat_i,
	input  logic                        ext_ack_i,
	input  logic                        ext_err_i,
	// peripheral bus
	output logic                        per_cyc_o,
	output logic                        per_stb_o,
	output logic                        per_we_o,
	output logic [mem_pkg::ADDR_W-1:0]  per_adr_o,
	output logic [mem_pkg::DATA_W-1:0]  per_dat_o,
	input  logic [mem_pkg::DATA_W-1:0]  per_dat_i,
	input  logic                        per_ack_i,
	// counters
	output logic [mem_pkg::CNT_W-1:0]   l1_hits_o,
	output logic [mem_pkg::CNT_W-1:0]   l2_hits_o,
	output logic [mem_pkg::CNT_W-1:0]   ext_reads_o
);

	// decode
	// ----------------------------------------------------------------------
	logic mem_cyc, mem_stb, dec_err, sel_per;

	addr_decode u_decode (
		.clock_i   (clock_i),
		.rst_i     (rst_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.adr_i     (adr_i),
		.mem_cyc_o (mem_cyc),
		.mem_stb_o (mem_stb),
		.per_cyc_o (per_cyc_o),
		.per_stb_o (per_stb_o),
		.dec_err_o (dec_err),
		.sel_per_o (sel_per)
	);

	assign per_we_o  = we_i;
	assign per_adr_o = adr_i;
	assign per_dat_o = dat_i;

	// cache pair
	// ----------------------------------------------------------------------
	logic [mem_pkg::DATA_W-1:0] l1_dat, l2_rd_dat, l1_wr_dat;
	logic [mem_pkg::ADDR_W-1:0] l1_l2_adr;
	logic l1_ack, l1_err, l1_hit;
	logic l1_l2_cyc, l1_l2_stb, l1_l2_we, l2_ack, l2_err, l2_hit, l2_miss;

	cache_level #(.LINES(mem_pkg::L1_LINES)) u_l1 (
		.clock_i (clock_i),     .rst_i   (rst_i),
		.s_cyc_i (mem_cyc),     .s_stb_i (mem_stb),   .s_we_i  (we_i),
		.s_adr_i (adr_i),       .s_dat_i (dat_i),     .s_dat_o (l1_dat),
		.s_ack_o (l1_ack),      .s_err_o (l1_err),
		.m_dat_i (l2_rd_dat),   .m_ack_i (l2_ack),    .m_err_i (l2_err),
		.m_cyc_o (l1_l2_cyc),   .m_stb_o (l1_l2_stb), .m_we_o  (l1_l2_we),
		.m_adr_o (l1_l2_adr),   .m_dat_o (l1_wr_dat),
		.hit_o   (l1_hit),      .miss_o  ()
	);

	cache_level #(.LINES(mem_pkg::L2_LINES)) u_l2 (
		.clock_i (clock_i),     .rst_i   (rst_i),
		.s_cyc_i (l1_l2_cyc),   .s_stb_i (l1_l2_stb), .s_we_i  (l1_l2_we),
		.s_adr_i (l1_l2_adr),   .s_dat_i (l1_wr_dat), .s_dat_o (l2_rd_dat),
		.s_ack_o (l2_ack),      .s_err_o (l2_err),
		.m_dat_i (ext_dat_i),   .m_ack_i (ext_ack_i), .m_err_i (ext_err_i),
		.m_cyc_o (ext_cyc_o),   .m_stb_o (ext_stb_o), .m_we_o  (ext_we_o),
		.m_adr_o (ext_adr_o),   .m_dat_o (ext_dat_o),
		.hit_o   (l2_hit),      .miss_o  (l2_miss)
	);

	// result
	// ----------------------------------------------------------------------
	resp_merge u_result (
		.clock_i         (clock_i),   .rst_i     (rst_i),
		.sel_per_i       (sel_per),
		.mem_ack_i       (l1_ack),    .mem_err_i (l1_err),   .mem_dat_i (l1_dat),
		.per_ack_i       (per_ack_i), .per_dat_i (per_dat_i),
		.dec_err_i       (dec_err),
		.l1_hit_i        (l1_hit),    .l2_hit_i  (l2_hit),   .ext_read_done_i (l2_miss),
		.dat_o           (dat_o),     .ack_o     (ack_o),    .err_o     (err_o),
		.l1_hits_o       (l1_hits_o), .l2_hits_o (l2_hits_o),
		.ext_reads_o     (ext_reads_o)
	);

endmodule

/* resp_merge.sv */
// ----------------------------------------------------------------------
// merges the memory, peripheral and decoder answers for the core and
// keeps saturating counters of L1 hits, L2 hits and external reads
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module resp_merge (
	input  logic                        clock_i,
	input  logic                        rst_i,
	input  logic                        sel_per_i,
	input  logic                        mem_ack_i,
	input  logic                        mem_err_i,
	input  logic [mem_pkg::DATA_W-1:0]  mem_dat_i,
	input  logic                        per_ack_i,
	input  logic [mem_pkg::DATA_W-1:0]  per_dat_i,
	input  logic                        dec_err_i,
	input  logic                        l1_hit_i,
	input  logic                        l2_hit_i,
	input  logic                        ext_read_done_i,
	output logic [mem_pkg::DATA_W-1:0]  dat_o,
	output logic                        ack_o,
	output logic                        err_o,
	output logic [mem_pkg::CNT_W-1:0]   l1_hits_o,
	output logic [mem_pkg::CNT_W-1:0]   l2_hits_o,
	output logic [mem_pkg::CNT_W-1:0]   ext_reads_o
);

	logic [2:0]                inc;
	logic [mem_pkg::CNT_W-1:0] cnt [3];

	// answer path back to the core
	// ----------------------------------------------------------------------
	assign dat_o = sel_per_i ? per_dat_i : mem_dat_i;
	assign ack_o = sel_per_i ? per_ack_i : mem_ack_i;
	// decoder err only fires when neither path was selected
	assign err_o = dec_err_i | (~sel_per_i & mem_err_i);

	// event counters
	// ----------------------------------------------------------------------
	assign inc = {ext_read_done_i, l2_hit_i, l1_hit_i};

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int i = 0; i < 3; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				// hold at all ones
				if (inc[i] && (cnt[i] != '1)) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign l1_hits_o   = cnt[0];
	assign l2_hits_o   = cnt[1];
	assign ext_reads_o = cnt[2];

endmodule

/* cache_level.sv */
// ----------------------------------------------------------------------
// direct-mapped write-through cache, one word per line, no write
// allocate; used as both L1 and L2 with a different LINES value
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cache_level #(
	parameter int LINES = 4
) (
	input  logic                        clock_i,
	input  logic                        rst_i,
	// slave side, towards the core
	input  logic                        s_cyc_i,
	input  logic                        s_stb_i,
	input  logic                        s_we_i,
	input  logic [mem_pkg::ADDR_W-1:0]  s_adr_i,
	input  logic [mem_pkg::DATA_W-1:0]  s_dat_i,
	output logic [mem_pkg::DATA_W-1:0]  s_dat_o,
	output logic                        s_ack_o,
	output logic                        s_err_o,
	// master side, towards the next level
	input  logic [mem_pkg::DATA_W-1:0]  m_dat_i,
	input  logic                        m_ack_i,
	input  logic                        m_err_i,
	output logic                        m_cyc_o,
	output logic                        m_stb_o,
	output logic                        m_we_o,
	output logic [mem_pkg::ADDR_W-1:0]  m_adr_o,
	output logic [mem_pkg::DATA_W-1:0]  m_dat_o,
	// event pulses for the counters
	output logic                        hit_o,
	output logic                        miss_o
);

	localparam int IDX_W = $clog2(LINES);
	localparam int TAG_W = mem_pkg::ADDR_W - 2 - IDX_W;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FORWARD,
		ST_RESPOND
	} state_t;

	state_t state;

	// line storage
	logic [LINES-1:0]          valid;
	logic [TAG_W-1:0]          tag_arr  [LINES];
	logic [mem_pkg::DATA_W-1:0] data_arr [LINES];

	// request held for the whole transaction
	logic                       we_q;
	logic [mem_pkg::ADDR_W-1:0] adr_q;
	logic [mem_pkg::DATA_W-1:0] dat_q;
	logic [mem_pkg::DATA_W-1:0] rsp_dat_q;
	logic                       err_q;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic line_hit;
	logic read_hit;
	logic fwd_active;
	logic fill_en;
	logic upd_en;

	// word address split into index and tag
	assign idx = adr_q[2 +: IDX_W];
	assign tag = adr_q[mem_pkg::ADDR_W-1 -: TAG_W];

	assign line_hit = valid[idx] && (tag_arr[idx] == tag);
	assign read_hit = (state == ST_LOOKUP) && !we_q && line_hit;

	// misses and all writes go down right from lookup
	assign fwd_active = ((state == ST_LOOKUP) && !read_hit) || (state == ST_FORWARD);

	assign fill_en = (state == ST_FORWARD) && m_ack_i && !m_err_i && !we_q;
	assign upd_en  = (state == ST_FORWARD) && m_ack_i && !m_err_i && we_q && line_hit;

	// slave side answers
	assign s_ack_o = read_hit || ((state == ST_RESPOND) && !err_q);
	assign s_err_o = (state == ST_RESPOND) && err_q;
	assign s_dat_o = (state == ST_RESPOND) ? rsp_dat_q : data_arr[idx];

	// master side request
	assign m_cyc_o = fwd_active;
	assign m_stb_o = fwd_active;
	assign m_we_o  = we_q;
	assign m_adr_o = adr_q;
	assign m_dat_o = dat_q;

	assign hit_o  = read_hit;
	// read filled from below without error
	assign miss_o = (state == ST_RESPOND) && !err_q && !we_q;

	// control FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state <= ST_IDLE;
			valid <= '0;
			err_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (s_cyc_i && s_stb_i) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					state <= read_hit ? ST_IDLE : ST_FORWARD;
				end
				ST_FORWARD: begin
					if (m_err_i) begin
						err_q <= 1'b1;
						state <= ST_RESPOND;
					end else if (m_ack_i) begin
						err_q <= 1'b0;
						state <= ST_RESPOND;
					end
					if (fill_en) begin
						valid[idx] <= 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// request capture and line fill
	always_ff @(posedge clock_i) begin
		if (state == ST_IDLE) begin
			we_q  <= s_we_i;
			adr_q <= s_adr_i;
			dat_q <= s_dat_i;
		end
		if (fill_en) begin
			tag_arr[idx]  <= tag;
			data_arr[idx] <= m_dat_i;
		end else if (upd_en) begin
			// write-through keeps a resident line current
			data_arr[idx] <= dat_q;
		end
		if ((state == ST_FORWARD) && m_ack_i) begin
			rsp_dat_q <= m_dat_i;
		end
	end

endmodule

/* addr_decode.sv */
// ----------------------------------------------------------------------
// core request decoder, steers the strobes to memory or peripherals
// and answers unmapped addresses with a single err pulse
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module addr_decode (
	input  logic                        clock_i,
	input  logic                        rst_i,
	input  logic                        cyc_i,
	input  logic                        stb_i,
	input  logic [mem_pkg::ADDR_W-1:0]  adr_i,
	output logic                        mem_cyc_o,
	output logic                        mem_stb_o,
	output logic                        per_cyc_o,
	output logic                        per_stb_o,
	output logic                        dec_err_o,
	output logic                        sel_per_o
);

	logic is_mem;
	logic is_per;
	logic req_unmapped;
	// request seen on the previous edge, blocks a repeated err
	logic err_held;

	// region compare
	assign is_mem = (adr_i & ~mem_pkg::MEM_MASK) == mem_pkg::MEM_BASE;
	assign is_per = (adr_i & ~mem_pkg::PER_MASK) == mem_pkg::PER_BASE;

	assign mem_cyc_o = cyc_i & is_mem;
	assign mem_stb_o = stb_i & is_mem;
	assign per_cyc_o = cyc_i & is_per;
	assign per_stb_o = stb_i & is_per;

	// tells the merger which path answers
	assign sel_per_o = is_per;

	assign req_unmapped = cyc_i & stb_i & ~is_mem & ~is_per;

	// unmapped access
	// ----------------------------------------------------------------------
	// err goes out once, on the first edge the request is seen
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			dec_err_o <= 1'b0;
			err_held  <= 1'b0;
		end else begin
			dec_err_o <= req_unmapped & ~err_held;
			// cleared once the master drops stb
			err_held  <= req_unmapped;
		end
	end

endmodule

/* mem_pkg.sv */
// ----------------------------------------------------------------------
// shared widths, address map and cache sizes for the memory subsystem
// referenced by scoped name from the decoder, caches and merger
// ----------------------------------------------------------------------

package mem_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// address map
	// ----------------------------------------------------------------------
	// cacheable memory, 64 KiB
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] MEM_MASK = 32'h0000_ffff;

	// reduced peripheral bus, 256 bytes
	localparam logic [ADDR_W-1:0] PER_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] PER_MASK = 32'h0000_00ff;

	// cache geometry
	// ----------------------------------------------------------------------
	// line counts, powers of two, one word per line
	localparam int L1_LINES = 4;
	localparam int L2_LINES = 16;

	// hit and miss counter width
	localparam int CNT_W = 16;

endpackage
